// File: Makefile
TOOL     = verilator
TOP      = tb_cnn_core
FILELIST = src.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJDIR   = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cnn_core.sv
`timescale 1ns/1ps

module cnn_core #(
    parameter int KX     = cnn_pkg::DEF_KX,
    parameter int KY     = cnn_pkg::DEF_KY,
    parameter int IX     = cnn_pkg::DEF_IX,
    parameter int CO     = cnn_pkg::DEF_CO,
    parameter int I_F_BW = cnn_pkg::DEF_I_F_BW,
    parameter int W_BW   = cnn_pkg::DEF_W_BW,
    parameter int B_BW   = cnn_pkg::DEF_B_BW,
    parameter int ACC_BW = cnn_pkg::DEF_ACC_BW,
    parameter int AR_BW  = cnn_pkg::DEF_AR_BW
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [CO*KX*KY*W_BW-1:0]       i_cnn_weight,
    input  logic [CO*B_BW-1:0]             i_cnn_bias,
    input  logic                           i_in_valid,
    input  logic [I_F_BW-1:0]              i_in_fmap,
    output logic                           o_ot_valid,
    output logic [CO*AR_BW-1:0]            o_ot_fmap
);

    localparam int K_W_BW = KX * KY * W_BW;
    // wide enough for kernel sum plus bias without overflow
    localparam int SUM_BW = ((ACC_BW > B_BW) ? ACC_BW : B_BW) + 1;

    // line buffer to kernels
    logic                      w_window_valid;
    logic [KX*KY*I_F_BW-1:0]   w_window;

    // kernel results
    logic [CO-1:0]             w_kernel_valid;
    logic signed [ACC_BW-1:0]  w_kernel_acc [0:CO-1];

    // ========================================
    // window generation
    // ========================================
    line_buffer #(
        .KX     (KX),
        .KY     (KY),
        .IX     (IX),
        .I_F_BW (I_F_BW)
    ) u_line_buffer (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_in_valid     (i_in_valid),
        .i_in_pixel     (i_in_fmap),
        .o_window_valid (w_window_valid),
        .o_window       (w_window)
    );

    // ========================================
    // kernels, bias and relu per channel
    // ========================================
    for (genvar g = 0; g < CO; g++) begin : gen_co
        logic signed [SUM_BW-1:0] bias_sum;
        logic [AR_BW-1:0]         r_relu;

        // channel g takes its own weight slice
        cnn_kernel #(
            .KX     (KX),
            .KY     (KY),
            .I_F_BW (I_F_BW),
            .W_BW   (W_BW),
            .ACC_BW (ACC_BW)
        ) u_cnn_kernel (
            .clk             (clk),
            .reset_n         (reset_n),
            .i_cnn_weight    (i_cnn_weight[g*K_W_BW +: K_W_BW]),
            .i_in_valid      (w_window_valid),
            .i_in_fmap       (w_window),
            .o_ot_valid      (w_kernel_valid[g]),
            .o_ot_kernel_acc (w_kernel_acc[g])
        );

        // sign-extended bias add
        assign bias_sum = w_kernel_acc[g] + $signed(i_cnn_bias[g*B_BW +: B_BW]);

        // negative clamps to zero, else keep the low bits
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                r_relu <= '0;
            end else if (&w_kernel_valid) begin
                r_relu <= bias_sum[SUM_BW-1] ? '0 : bias_sum[AR_BW-1:0];
            end
        end

        // channel 0 in the low bits
        assign o_ot_fmap[g*AR_BW +: AR_BW] = r_relu;
    end

    // output valid follows the bias stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= &w_kernel_valid;
        end
    end

endmodule

// File: cnn_core_sva.sv
`timescale 1ns/1ps

module cnn_core_sva #(
    parameter int CO    = cnn_pkg::DEF_CO,
    parameter int AR_BW = cnn_pkg::DEF_AR_BW
) (
    input logic                clk,
    input logic                reset_n,
    input logic                i_in_valid,
    input logic                o_ot_valid,
    input logic [CO*AR_BW-1:0] o_ot_fmap
);

    // pixel taken to output valid, in clock edges
    localparam int LATENCY = 4;

    // assertion failures so far
    int fail_count = 0;

    // ========================================
    // reset and latency
    // ========================================
    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !o_ot_valid)
        else begin
            $error("o_ot_valid high during reset");
            fail_count++;
        end

    // every output traces back to a taken pixel
    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> $past(i_in_valid, LATENCY))
        else begin
            $error("o_ot_valid without a pixel %0d cycles before", LATENCY);
            fail_count++;
        end

    // ========================================
    // clamp range per channel
    // ========================================
    for (genvar g = 0; g < CO; g++) begin : gen_range
        // top bit never set by the clamp
        a_range: assert property (@(posedge clk) disable iff (!reset_n)
            o_ot_valid |-> !o_ot_fmap[g*AR_BW + AR_BW - 1])
            else begin
                $error("channel %0d result out of clamp range", g);
                fail_count++;
            end
    end

endmodule

bind cnn_core cnn_core_sva #(
    .CO    (CO),
    .AR_BW (AR_BW)
) u_cnn_core_sva (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_in_valid (i_in_valid),
    .o_ot_valid (o_ot_valid),
    .o_ot_fmap  (o_ot_fmap)
);

// File: cnn_kernel.sv
`timescale 1ns/1ps

module cnn_kernel #(
    parameter int KX     = cnn_pkg::DEF_KX,
    parameter int KY     = cnn_pkg::DEF_KY,
    parameter int I_F_BW = cnn_pkg::DEF_I_F_BW,
    parameter int W_BW   = cnn_pkg::DEF_W_BW,
    parameter int ACC_BW = cnn_pkg::DEF_ACC_BW
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic signed [KX*KY*W_BW-1:0]   i_cnn_weight,
    input  logic                           i_in_valid,
    input  logic [KX*KY*I_F_BW-1:0]        i_in_fmap,
    output logic                           o_ot_valid,
    output logic signed [ACC_BW-1:0]       o_ot_kernel_acc
);

    localparam int TAPS   = KX * KY;
    // zero-extended pixel times signed weight
    localparam int MUL_BW = I_F_BW + 1 + W_BW;

    // valid bit per pipeline stage
    logic [1:0] r_valid;

    // stage 1 products
    logic signed [MUL_BW-1:0] r_prod [0:TAPS-1];

    // adder tree input to stage 2
    logic signed [ACC_BW-1:0] sum_c;

    // ========================================
    // valid pipeline
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 2'b00;
        end else begin
            r_valid <= {r_valid[0], i_in_valid};
        end
    end

    assign o_ot_valid = r_valid[1];

    // ========================================
    // stage 1 multiply
    // ========================================
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int i = 0; i < TAPS; i++) begin
                // pixel is unsigned, add a zero sign bit before the
                // signed multiply
                r_prod[i] <= $signed({1'b0, i_in_fmap[i*I_F_BW +: I_F_BW]})
                           * $signed(i_cnn_weight[i*W_BW +: W_BW]);
            end
        end
    end

    // ========================================
    // stage 2 sum
    // ========================================

    // all operands signed, so each product sign-extends to ACC_BW
    always_comb begin
        sum_c = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum_c = sum_c + r_prod[i];
        end
    end

    // register the sum only when stage 1 held a window
    always_ff @(posedge clk) begin
        if (r_valid[0]) begin
            o_ot_kernel_acc <= sum_c;
        end
    end

endmodule

// File: cnn_pkg.sv
package cnn_pkg;

    // ========================================
    // default layer sizes
    // ========================================

    // kernel width and height
    parameter int DEF_KX = 3;
    parameter int DEF_KY = 3;

    // square input image, side length in pixels
    parameter int DEF_IX = 8;

    // output channels, one kernel unit each
    parameter int DEF_CO = 2;

    // ========================================
    // data widths
    // ========================================

    // unsigned pixel
    parameter int DEF_I_F_BW = 8;

    // signed weight and signed bias
    parameter int DEF_W_BW = 8;
    parameter int DEF_B_BW = 16;

    // kernel sum: pixel x weight product, plus growth for KX*KY terms,
    // plus one bit of headroom for the zero-extended pixel sign
    parameter int DEF_ACC_BW = DEF_I_F_BW + DEF_W_BW + $clog2(DEF_KX * DEF_KY) + 1;

    // clamped result is never negative, so the sign bit is dropped
    parameter int DEF_AR_BW = DEF_ACC_BW - 1;

endpackage

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int KX     = cnn_pkg::DEF_KX,
    parameter int KY     = cnn_pkg::DEF_KY,
    parameter int IX     = cnn_pkg::DEF_IX,
    parameter int I_F_BW = cnn_pkg::DEF_I_F_BW
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_in_valid,
    input  logic [I_F_BW-1:0]          i_in_pixel,
    output logic                       o_window_valid,
    output logic [KX*KY*I_F_BW-1:0]    o_window
);

    localparam int CNT_BW = (IX > 1) ? $clog2(IX) : 1;

    // position of the incoming pixel
    logic [CNT_BW-1:0] col;
    logic [CNT_BW-1:0] row;
    logic              window_done;

    // previous KY-1 rows, index 0 is the oldest
    logic [I_F_BW-1:0] row_mem [0:KY-2][0:IX-1];

    // one vertical column of the window, oldest row first
    logic [I_F_BW-1:0] tap [0:KY-1];

    // window registers, [row][column], column KX-1 is the newest
    logic [I_F_BW-1:0] win [0:KY-1][0:KX-1];

    // ========================================
    // position counters
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_in_valid) begin
            if (col == CNT_BW'(IX - 1)) begin
                col <= '0;
                // wrap at end of frame so the next frame starts clean
                row <= (row == CNT_BW'(IX - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // window is full once enough columns and rows have been seen
    assign window_done = (col >= CNT_BW'(KX - 1)) && (row >= CNT_BW'(KY - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_window_valid <= 1'b0;
        end else begin
            o_window_valid <= i_in_valid && window_done;
        end
    end

    // ========================================
    // row memories and window shift
    // ========================================
    always_comb begin
        for (int k = 0; k < KY - 1; k++) begin
            tap[k] = row_mem[k][col];
        end
        // bottom of the column is the live pixel
        tap[KY-1] = i_in_pixel;
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            // each row moves up one slot at this column
            for (int k = 0; k < KY - 1; k++) begin
                row_mem[k][col] <= tap[k+1];
            end
            // shift left, new column enters at the right
            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX - 1; kx++) begin
                    win[ky][kx] <= win[ky][kx+1];
                end
                win[ky][KX-1] <= tap[ky];
            end
        end
    end

    // flatten row-major, element 0 in the low bits
    always_comb begin
        for (int ky = 0; ky < KY; ky++) begin
            for (int kx = 0; kx < KX; kx++) begin
                o_window[(ky*KX+kx)*I_F_BW +: I_F_BW] = win[ky][kx];
            end
        end
    end

endmodule

// File: src.f
cnn_pkg.sv
line_buffer.sv
cnn_kernel.sv
cnn_core.sv
cnn_core_sva.sv
tb_cnn_core.sv

// File: tb_cnn_core.sv
`timescale 1ns/1ps

module tb_cnn_core;

    import cnn_pkg::*;

    localparam int KX    = DEF_KX;
    localparam int KY    = DEF_KY;
    localparam int IX    = DEF_IX;
    localparam int CO    = DEF_CO;
    localparam int TAPS  = KX * KY;
    localparam int NPIX  = IX * IX;
    localparam int N_OUT = (IX - KX + 1) * (IX - KY + 1);
    // five frames in all, 4 ns per pixel, 3x margin
    localparam int WATCHDOG_NS = 5 * NPIX * 4 * 3 + 200;

    logic                         clk = 1'b0;
    logic                         reset_n;
    logic                         i_in_valid;
    logic [DEF_I_F_BW-1:0]        i_in_fmap;
    logic [CO*TAPS*DEF_W_BW-1:0]  i_cnn_weight;
    logic [CO*DEF_B_BW-1:0]       i_cnn_bias;
    logic                         o_ot_valid;
    logic [CO*DEF_AR_BW-1:0]      o_ot_fmap;

    integer seed = 32'hc2c36647;

    // current frame and layer parameters for the model
    int frame [0:NPIX-1];
    int wt [0:CO-1][0:TAPS-1];
    int bias [0:CO-1];
    int wt_keep [0:CO-1][0:TAPS-1];
    int bias_keep [0:CO-1];

    // expected results and completing-pixel cycles, raster order
    logic [CO*DEF_AR_BW-1:0] exp_q [$];
    logic [CO*DEF_AR_BW-1:0] exp_val;
    int lat_q [$];
    int took;
    int cycle_cnt = 0;
    int mon_col = 0;
    int mon_row = 0;
    int out_cnt = 0;
    int out_base = 0;
    int err_cnt = 0;
    int err_base = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    always #2 clk = ~clk;

    cnn_core #(
        .KX (KX),
        .KY (KY),
        .IX (IX),
        .CO (CO)
    ) dut (.*);

    // ========================================
    // output monitor
    // ========================================
    always @(posedge clk) begin
        if (o_ot_valid) begin
            out_cnt++;
            assert (exp_q.size() > 0) else begin
                $display("extra output at cycle %0d, nothing was expected", cycle_cnt);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                assert (o_ot_fmap == exp_val) else begin
                    $display("** Error o_ot_fmap expected %h got %h", exp_val, o_ot_fmap);
                    err_cnt++;
                end
            end
            if (lat_q.size() > 0) begin
                took = lat_q.pop_front();
                assert (cycle_cnt - took == 4) else begin
                    $display("** Error o_ot_valid latency expected %h got %h",
                             4, cycle_cnt - took);
                    err_cnt++;
                end
            end
        end
        // own position count, window completes at col >= KX-1, row >= KY-1
        if (reset_n && i_in_valid) begin
            if (mon_col >= KX - 1 && mon_row >= KY - 1) begin
                lat_q.push_back(cycle_cnt);
            end
            if (mon_col == IX - 1) begin
                mon_col = 0;
                mon_row = (mon_row == IX - 1) ? 0 : mon_row + 1;
            end else begin
                mon_col++;
            end
        end
        cycle_cnt++;
    end

    // ========================================
    // stimulus and model helpers
    // ========================================
    task automatic make_frame();
        for (int p = 0; p < NPIX; p++) begin
            frame[p] = $random(seed) & 32'hff;
        end
    endtask

    // signed weights in -127..127, small positive bias
    task automatic random_weights(input int ch);
        for (int i = 0; i < TAPS; i++) begin
            wt[ch][i] = $random(seed) % 128;
        end
        bias[ch] = $unsigned($random(seed)) % 2000;
    endtask

    task automatic set_weights();
        logic [CO*TAPS*DEF_W_BW-1:0] wv;
        logic [CO*DEF_B_BW-1:0]      bv;
        for (int g = 0; g < CO; g++) begin
            for (int i = 0; i < TAPS; i++) begin
                wv[(g*TAPS+i)*DEF_W_BW +: DEF_W_BW] = DEF_W_BW'(wt[g][i]);
            end
            bv[g*DEF_B_BW +: DEF_B_BW] = DEF_B_BW'(bias[g]);
        end
        @(posedge clk);
        i_cnn_weight <= wv;
        i_cnn_bias   <= bv;
    endtask

    // sum of pixel x weight plus bias, negative -> 0, low AR bits
    task automatic push_expected();
        longint                  acc;
        logic [CO*DEF_AR_BW-1:0] ev;
        for (int r = KY - 1; r < IX; r++) begin
            for (int c = KX - 1; c < IX; c++) begin
                for (int g = 0; g < CO; g++) begin
                    acc = longint'(bias[g]);
                    for (int ky = 0; ky < KY; ky++) begin
                        for (int kx = 0; kx < KX; kx++) begin
                            acc += longint'(frame[(r-KY+1+ky)*IX + c-KX+1+kx])
                                 * longint'(wt[g][ky*KX+kx]);
                        end
                    end
                    ev[g*DEF_AR_BW +: DEF_AR_BW] = (acc < 0) ? '0 : acc[DEF_AR_BW-1:0];
                end
                exp_q.push_back(ev);
            end
        end
    endtask

    // up to max_gap idle cycles after each pixel
    task automatic drive_frame(input int max_gap);
        int gaps;
        for (int p = 0; p < NPIX; p++) begin
            @(posedge clk);
            i_in_valid <= 1'b1;
            i_in_fmap  <= DEF_I_F_BW'(frame[p]);
            gaps = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
            repeat (gaps) begin
                @(posedge clk);
                i_in_valid <= 1'b0;
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        i_in_valid <= 1'b0;
    endtask

    task automatic end_test(input string name, input int n_exp);
        int waited;
        int errs;
        waited = 0;
        while (exp_q.size() != 0 && waited < 32) begin
            @(posedge clk);
            waited++;
        end
        // quiet window, catches stray outputs
        repeat (8) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected outputs never appeared", name, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        assert (out_cnt - out_base == n_exp) else begin
            $display("%s: got %0d outputs instead of %0d", name, out_cnt - out_base, n_exp);
            err_cnt++;
        end
        lat_q.delete();
        errs = err_cnt + dut.u_cnn_core_sva.fail_count;
        if (errs == err_base) begin
            pass_cnt++;
            $display("%s: pass, %0d outputs", name, out_cnt - out_base);
        end else begin
            fail_cnt++;
            $display("%s: FAIL, %0d errors", name, errs - err_base);
        end
        out_base = out_cnt;
        err_base = errs;
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        reset_n      = 1'b0;
        i_in_valid   = 1'b0;
        i_in_fmap    = '0;
        i_cnn_weight = '0;
        i_cnn_bias   = '0;

        // test 1: no output through reset and idle
        repeat (4) begin
            @(posedge clk);
            assert (!o_ot_valid) else begin
                $display("** Error o_ot_valid expected %h got %h", 1'b0, o_ot_valid);
                err_cnt++;
            end
        end
        reset_n <= 1'b1;
        repeat (6) @(posedge clk);
        end_test("test 1 reset", 0);

        // test 2: continuous frame, random weights, positive bias
        make_frame();
        for (int g = 0; g < CO; g++) begin
            random_weights(g);
        end
        set_weights();
        push_expected();
        drive_frame(0);
        go_idle();
        end_test("test 2 full frame", N_OUT);
        wt_keep   = wt;
        bias_keep = bias;

        // test 3: last channel all negative, same frame
        for (int i = 0; i < TAPS; i++) begin
            wt[CO-1][i] = -1 - int'($unsigned($random(seed)) % 128);
        end
        bias[CO-1] = -30000;
        set_weights();
        push_expected();
        drive_frame(0);
        go_idle();
        end_test("test 3 relu clamp", N_OUT);

        // test 4: test 2 again with idle gaps
        wt   = wt_keep;
        bias = bias_keep;
        set_weights();
        push_expected();
        drive_frame(2);
        go_idle();
        end_test("test 4 gapped input", N_OUT);

        // test 5: two new frames with no gap between them
        make_frame();
        for (int g = 0; g < CO; g++) begin
            random_weights(g);
        end
        set_weights();
        push_expected();
        drive_frame(0);
        make_frame();
        push_expected();
        drive_frame(0);
        go_idle();
        end_test("test 5 back-to-back frames", 2 * N_OUT);

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
